//--- hdl/eeprom_pkg.sv
package eeprom_pkg;

    // data and address widths
    localparam int BYTE_W    = 8;
    localparam int BLOCK_W   = 3;
    localparam int ADDR_W    = BLOCK_W + BYTE_W;
    localparam int MEM_WORDS = 1 << ADDR_W;

    // credit counters hold 0 up to the largest buffer depth
    localparam int CREDIT_W = 3;

    // upper nibble of a valid control byte
    localparam logic [3:0] DEV_CODE = 4'b1010;

    // buffer depths
    localparam int IN_DEPTH  = 4;
    localparam int OP_DEPTH  = 2;
    localparam int OUT_DEPTH = 4;

    localparam int IN_PTR_W  = $clog2(IN_DEPTH);
    localparam int OP_PTR_W  = $clog2(OP_DEPTH);
    localparam int OUT_PTR_W = $clog2(OUT_DEPTH);

    // one data, control, address or count byte
    typedef logic [BYTE_W-1:0] byte_t;

    // block bits on top of the low byte
    typedef logic [ADDR_W-1:0] mem_addr_t;

    typedef logic [BLOCK_W-1:0] block_t;

    typedef logic [CREDIT_W-1:0] credit_cnt_t;

    // frame decoder states
    typedef enum logic [2:0]
    {
        IDLE,
        WR_ADDR,
        WR_DATA,
        RD_COUNT,
        RD_ISSUE,
        SKIP
    } frame_state_t;

endpackage

//--- hdl/eeprom_op_if.sv
`timescale 1ns/1ps

interface eeprom_op_if import eeprom_pkg::*;
();

    // one memory operation per op_valid cycle
    logic      op_valid;
    logic      op_write;
    mem_addr_t op_addr;
    byte_t     op_data;

    // one pulse per freed slot
    logic      op_credit;

    modport decoder
    (
        output op_valid,
        output op_write,
        output op_addr,
        output op_data,
        input  op_credit
    );

    modport executor
    (
        input  op_valid,
        input  op_write,
        input  op_addr,
        input  op_data,
        output op_credit
    );

endinterface

//--- hdl/frame_decoder.sv
`timescale 1ns/1ps

module frame_decoder import eeprom_pkg::*;
(
    input  logic         scl,
    input  logic         rst_n,
    input  logic         in_valid,
    input  logic         in_start,
    input  byte_t        in_data,
    output logic         in_credit,
    eeprom_op_if.decoder op
);

    byte_t               fifo_data [IN_DEPTH];
    logic                fifo_start [IN_DEPTH];
    logic [IN_PTR_W-1:0] wr_ptr;
    logic [IN_PTR_W-1:0] rd_ptr;
    credit_cnt_t         in_count;
    credit_cnt_t         op_cnt;
    frame_state_t        state;
    block_t              block_q;
    byte_t               addr_lo;
    byte_t               rd_left;
    logic                head_start;
    byte_t               head_data;
    logic                pop;
    logic                issue_wr;
    logic                issue_rd;

    assign head_start = fifo_start[rd_ptr];
    assign head_data  = fifo_data[rd_ptr];

    // read frames drain before the next byte is looked at
    assign pop = (in_count != '0) && (state != RD_ISSUE) &&
                 (head_start || state != WR_DATA || op_cnt != '0);

    assign issue_wr = pop && !head_start && (state == WR_DATA);
    assign issue_rd = (state == RD_ISSUE) && (op_cnt != '0);

    always_ff @(posedge scl)
    begin
        if (in_valid)
        begin
            fifo_data[wr_ptr]  <= in_data;
            fifo_start[wr_ptr] <= in_start;
        end
    end

    always_ff @(posedge scl or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            in_count  <= '0;
            in_credit <= 1'b0;
            op_cnt    <= credit_cnt_t'(OP_DEPTH);
        end
        else
        begin
            if (in_valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            in_count  <= in_count + credit_cnt_t'(in_valid) - credit_cnt_t'(pop);
            in_credit <= pop;
            op_cnt    <= op_cnt - credit_cnt_t'(issue_wr | issue_rd)
                         + credit_cnt_t'(op.op_credit);
        end
    end

    always_ff @(posedge scl or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state   <= IDLE;
            block_q <= '0;
            addr_lo <= '0;
            rd_left <= '0;
        end
        else if (pop && head_start)
        begin
            if (head_data[7:4] == DEV_CODE)
            begin
                block_q <= head_data[3:1];
                if (head_data[0])
                    state <= RD_COUNT;
                else
                    state <= WR_ADDR;
            end
            else
                state <= SKIP;
        end
        else if (pop)
        begin
            case (state)
                WR_ADDR:
                begin
                    addr_lo <= head_data;
                    state   <= WR_DATA;
                end
                WR_DATA:
                    addr_lo <= addr_lo + 8'd1;
                RD_COUNT:
                begin
                    rd_left <= head_data;
                    if (head_data == '0)
                        state <= IDLE;
                    else
                        state <= RD_ISSUE;
                end
                default:
                    state <= state;
            endcase
        end
        else if (issue_rd)
        begin
            addr_lo <= addr_lo + 8'd1;
            rd_left <= rd_left - 8'd1;
            if (rd_left == 8'd1)
                state <= IDLE;
        end
    end

    always_ff @(posedge scl or negedge rst_n)
    begin
        if (!rst_n)
            op.op_valid <= 1'b0;
        else
            op.op_valid <= issue_wr | issue_rd;
    end

    // pointer wraps inside the block
    always_ff @(posedge scl)
    begin
        op.op_write <= issue_wr;
        op.op_addr  <= {block_q, addr_lo};
        op.op_data  <= head_data;
    end

endmodule

//--- hdl/array_executor.sv
`timescale 1ns/1ps

module array_executor import eeprom_pkg::*;
(
    input  logic          scl,
    input  logic          rst_n,
    eeprom_op_if.executor op,
    output logic          rd_push,
    output byte_t         rd_byte,
    input  logic          rd_free
);

    byte_t               mem [MEM_WORDS];
    logic                pend_write [OP_DEPTH];
    mem_addr_t           pend_addr [OP_DEPTH];
    byte_t               pend_data [OP_DEPTH];
    logic [OP_PTR_W-1:0] pend_wr;
    logic [OP_PTR_W-1:0] pend_rd;
    credit_cnt_t         pend_cnt;
    credit_cnt_t         free_cnt;
    logic                from_pend;
    logic                cur_valid;
    logic                cur_write;
    mem_addr_t           cur_addr;
    byte_t               cur_data;
    logic                do_write;
    logic                do_read;
    logic                park;
    logic                s1_valid;
    byte_t               s1_data;

    // parked ops go first so order is kept
    assign from_pend = (pend_cnt != '0);
    assign cur_valid = from_pend || op.op_valid;
    assign cur_write = from_pend ? pend_write[pend_rd] : op.op_write;
    assign cur_addr  = from_pend ? pend_addr[pend_rd] : op.op_addr;
    assign cur_data  = from_pend ? pend_data[pend_rd] : op.op_data;

    // a write waits one cycle if a read credit goes back at the same time
    assign do_write = cur_valid && cur_write && !rd_push;
    assign do_read  = cur_valid && !cur_write && (free_cnt != '0);
    assign park     = op.op_valid && (from_pend || !(do_write || do_read));

    always_ff @(posedge scl)
    begin
        if (park)
        begin
            pend_write[pend_wr] <= op.op_write;
            pend_addr[pend_wr]  <= op.op_addr;
            pend_data[pend_wr]  <= op.op_data;
        end
    end

    always_ff @(posedge scl)
    begin
        if (do_write)
            mem[cur_addr] <= cur_data;
        if (do_read)
            s1_data <= mem[cur_addr];
        rd_byte <= s1_data;
    end

    always_ff @(posedge scl or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pend_wr      <= '0;
            pend_rd      <= '0;
            pend_cnt     <= '0;
            free_cnt     <= credit_cnt_t'(OUT_DEPTH);
            s1_valid     <= 1'b0;
            rd_push      <= 1'b0;
            op.op_credit <= 1'b0;
        end
        else
        begin
            if (park)
                pend_wr <= pend_wr + 1'b1;
            if (from_pend && (do_write || do_read))
                pend_rd <= pend_rd + 1'b1;
            pend_cnt <= pend_cnt + credit_cnt_t'(park)
                        - credit_cnt_t'(from_pend && (do_write || do_read));
            free_cnt <= free_cnt - credit_cnt_t'(do_read) + credit_cnt_t'(rd_free);
            s1_valid <= do_read;
            rd_push  <= s1_valid;
            // read slots free up once the byte sits in the queue
            op.op_credit <= do_write | rd_push;
        end
    end

endmodule

//--- hdl/read_return_queue.sv
`timescale 1ns/1ps

module read_return_queue import eeprom_pkg::*;
(
    input  logic  scl,
    input  logic  rst_n,
    input  logic  rd_push,
    input  byte_t rd_byte,
    output logic  rd_free,
    output logic  out_valid,
    output byte_t out_data,
    input  logic  out_credit
);

    byte_t                q_data [OUT_DEPTH];
    logic [OUT_PTR_W-1:0] q_wr;
    logic [OUT_PTR_W-1:0] q_rd;
    credit_cnt_t          q_count;
    credit_cnt_t          host_credit;

    // head goes out as soon as a credit is held
    assign out_valid = (q_count != '0) && (host_credit != '0);
    assign out_data  = q_data[q_rd];

    always_ff @(posedge scl)
    begin
        if (rd_push)
            q_data[q_wr] <= rd_byte;
    end

    always_ff @(posedge scl or negedge rst_n)
    begin
        if (!rst_n)
        begin
            q_wr        <= '0;
            q_rd        <= '0;
            q_count     <= '0;
            host_credit <= '0;
            rd_free     <= 1'b0;
        end
        else
        begin
            if (rd_push)
                q_wr <= q_wr + 1'b1;
            if (out_valid)
                q_rd <= q_rd + 1'b1;
            q_count     <= q_count + credit_cnt_t'(rd_push) - credit_cnt_t'(out_valid);
            host_credit <= host_credit + credit_cnt_t'(out_credit)
                           - credit_cnt_t'(out_valid);
            // one free entry back to execute per byte sent
            rd_free     <= out_valid;
        end
    end

endmodule

//--- hdl/serial_eeprom.sv
`timescale 1ns/1ps

module serial_eeprom import eeprom_pkg::*;
(
    input  logic  scl,
    input  logic  rst_n,
    input  logic  in_valid,
    input  logic  in_start,
    input  byte_t in_data,
    output logic  in_credit,
    output logic  out_valid,
    output byte_t out_data,
    input  logic  out_credit
);

    logic  rd_push;
    byte_t rd_byte;
    logic  rd_free;

    eeprom_op_if u_op_if ();

    frame_decoder u_frame_decoder
    (
        .scl       (scl),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_start  (in_start),
        .in_data   (in_data),
        .in_credit (in_credit),
        .op        (u_op_if.decoder)
    );

    array_executor u_array_executor
    (
        .scl     (scl),
        .rst_n   (rst_n),
        .op      (u_op_if.executor),
        .rd_push (rd_push),
        .rd_byte (rd_byte),
        .rd_free (rd_free)
    );

    read_return_queue u_read_return_queue
    (
        .scl        (scl),
        .rst_n      (rst_n),
        .rd_push    (rd_push),
        .rd_byte    (rd_byte),
        .rd_free    (rd_free),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_credit (out_credit)
    );

endmodule

//--- tests/serial_eeprom_props.sv
`timescale 1ns/1ps

module serial_eeprom_props import eeprom_pkg::*;
(
    input logic        scl,
    input logic        rst_n,
    input logic        strobe,
    input logic        incoming,
    input logic        outgoing,
    input logic        full,
    input logic        grant,
    input logic        send,
    input credit_cnt_t credit_init
);

    // occupancy and held credit as seen from the ports
    int fill;
    int held;

    always_ff @(posedge scl or negedge rst_n)
    begin
        if (!rst_n)
        begin
            fill <= 0;
            held <= int'(credit_init);
        end
        else
        begin
            fill <= fill + int'(incoming) - int'(outgoing);
            held <= held + int'(grant) - int'(send);
        end
    end

    // strobe quiet while reset is held
    quiet_in_reset: assert property (@(posedge scl) !rst_n |-> !strobe)
        else $error("strobe high during reset");

    // and on the first edge after release
    quiet_after_reset: assert property (@(posedge scl) $rose(rst_n) |-> !strobe)
        else $error("strobe high right after reset");

    // a byte or operation only goes out against a held credit
    send_needs_credit: assert property
        (@(posedge scl) disable iff (!rst_n) send |-> (held > 0))
        else $error("send without credit");

    no_overflow: assert property
        (@(posedge scl) disable iff (!rst_n) (incoming && !outgoing) |-> !full)
        else $error("buffer written while full");

    no_pop_when_empty: assert property
        (@(posedge scl) disable iff (!rst_n) outgoing |-> (fill > 0))
        else $error("buffer read while empty");

endmodule

//--- tests/tb_serial_eeprom.sv
`timescale 1ns/1ps

module tb_serial_eeprom import eeprom_pkg::*;
();

    localparam int LIMIT = 2000;

    logic   scl;
    logic   rst_n;
    logic   in_valid;
    logic   in_start;
    byte_t  in_data;
    logic   in_credit;
    logic   out_valid;
    byte_t  out_data;
    logic   out_credit = 1'b0;

    byte_t  ref_mem [MEM_WORDS];
    byte_t  rx_data [256];
    int     rx_count = 0;
    int     rx_expected = 0;
    int     granted = 0;
    int     credit_ahead = 0;
    int     credit_returned = 0;
    logic   grant_on = 1'b0;
    integer seed = 86833;
    int     bytes_sent;
    byte_t  ptr_lo;
    int     pattern_salt;
    int     errors;
    int     tests;
    int     test_errors;
    logic   timed_out;
    int     rd_base;
    block_t rd_blk;
    byte_t  rd_lo;
    int     rd_n;
    int     sent0;
    int     ret0;

    serial_eeprom u_serial_eeprom
    (
        .scl        (scl),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_start   (in_start),
        .in_data    (in_data),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_credit (out_credit)
    );

    bind frame_decoder serial_eeprom_props u_decoder_props
    (
        .scl         (scl),
        .rst_n       (rst_n),
        .strobe      (in_credit),
        .incoming    (in_valid),
        .outgoing    (pop),
        .full        (in_count == IN_DEPTH),
        .grant       (op.op_credit),
        .send        (op.op_valid),
        .credit_init (credit_cnt_t'(OP_DEPTH))
    );

    bind read_return_queue serial_eeprom_props u_queue_props
    (
        .scl         (scl),
        .rst_n       (rst_n),
        .strobe      (out_valid),
        .incoming    (rd_push),
        .outgoing    (out_valid),
        .full        (q_count == OUT_DEPTH),
        .grant       (out_credit),
        .send        (out_valid),
        .credit_init ('0)
    );

    initial
    begin
        scl = 1'b0;
        forever #4 scl = ~scl;
    end

    // host side of both credit loops
    always @(negedge scl)
    begin
        if (in_credit)
            credit_returned <= credit_returned + 1;
        if (out_valid)
        begin
            rx_data[rx_count % 256] <= out_data;
            rx_count <= rx_count + 1;
        end
    end

    // random grants, at most the reads still owed plus any spare
    always @(negedge scl)
    begin
        if (grant_on && (granted < rx_expected + credit_ahead) && (granted - rx_count < 4)
            && ($random(seed) & 1))
        begin
            out_credit <= 1'b1;
            granted    <= granted + 1;
        end
        else
            out_credit <= 1'b0;
    end

    task automatic check_value(input string name, input int expected, input int actual);
        assert (actual == expected)
        else
        begin
            $display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        errors++;
        timed_out = 1'b1;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) @(negedge scl);
    endtask

    task automatic send_byte(input logic start, input byte_t data);
        int n;
        n = 0;
        while (!timed_out && (bytes_sent - credit_returned >= IN_DEPTH))
        begin
            @(negedge scl);
            n++;
            if (n > LIMIT)
                report_timeout("an input credit");
        end
        in_valid = 1'b1;
        in_start = start;
        in_data  = data;
        bytes_sent++;
        @(negedge scl);
        in_valid = 1'b0;
        in_start = 1'b0;
    endtask

    task automatic wait_rx(input int target);
        int n;
        n = 0;
        while (!timed_out && (rx_count < target))
        begin
            @(negedge scl);
            n++;
            if (n > LIMIT)
                report_timeout("read bytes on out_valid");
        end
    endtask

    task automatic wait_credits_back();
        int n;
        n = 0;
        while (!timed_out && (credit_returned != bytes_sent))
        begin
            @(negedge scl);
            n++;
            if (n > LIMIT)
                report_timeout("in_credit for every byte sent");
        end
    endtask

    // data depends on block and low byte
    task automatic write_frame(input block_t blk, input byte_t lo, input int n);
        byte_t     d;
        mem_addr_t a;
        send_byte(1'b1, {DEV_CODE, blk, 1'b0});
        send_byte(1'b0, lo);
        ptr_lo = lo;
        for (int i = 0; i < n; i++)
        begin
            a = {blk, ptr_lo};
            d = byte_t'(int'(a) * 37 + int'(blk) * 29 + pattern_salt);
            ref_mem[a] = d;
            send_byte(1'b0, d);
            ptr_lo++;
        end
        pattern_salt += 11;
    endtask

    task automatic set_pointer(input block_t blk, input byte_t lo);
        write_frame(blk, lo, 0);
    endtask

    task automatic start_read(input block_t blk, input int n);
        rd_base = rx_expected;
        rd_blk  = blk;
        rd_lo   = ptr_lo;
        rd_n    = n;
        rx_expected <= rx_expected + n;
        send_byte(1'b1, {DEV_CODE, blk, 1'b1});
        send_byte(1'b0, byte_t'(n));
        ptr_lo = ptr_lo + byte_t'(n);
    endtask

    task automatic finish_read(input string name);
        wait_rx(rd_base + rd_n);
        for (int i = 0; i < rd_n; i++)
            check_value(name, ref_mem[{rd_blk, byte_t'(rd_lo + i)}],
                        rx_data[(rd_base + i) % 256]);
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_errors)
            $display("test %-14s ok", name);
        else
            $display("test %-14s %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    initial
    begin
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_start     = 1'b0;
        in_data      = '0;
        bytes_sent   = 0;
        ptr_lo       = '0;
        pattern_salt = 5;
        errors       = 0;
        tests        = 0;
        test_errors  = 0;
        timed_out    = 1'b0;
        repeat (16) @(posedge scl);
        @(negedge scl);
        rst_n = 1'b1;

        for (int i = 0; i < 8; i++)
        begin
            @(negedge scl);
            check_value("reset", 0, out_valid);
            check_value("reset", 0, in_credit);
        end
        check_value("reset", 0, rx_count);
        end_test("reset");

        grant_on <= 1'b1;
        write_frame(3'd3, 8'h40, 6);
        set_pointer(3'd3, 8'h40);
        start_read(3'd3, 6);
        finish_read("write_read");
        end_test("write_read");

        // last two bytes land at 00 and 01
        write_frame(3'd1, 8'hFE, 4);
        set_pointer(3'd1, 8'h00);
        start_read(3'd1, 2);
        finish_read("page_wrap");
        end_test("page_wrap");

        write_frame(3'd2, 8'h10, 1);
        write_frame(3'd6, 8'h10, 1);
        set_pointer(3'd2, 8'h10);
        start_read(3'd2, 1);
        finish_read("block_split");
        set_pointer(3'd6, 8'h10);
        start_read(3'd6, 1);
        finish_read("block_split");
        end_test("block_split");

        sent0 = bytes_sent;
        ret0  = credit_returned;
        // spare out credits so a wrongly decoded read would show up
        credit_ahead <= 4;
        send_byte(1'b1, {4'b0110, 3'd3, 1'b0});
        send_byte(1'b0, 8'h40);
        send_byte(1'b0, 8'hA5);
        send_byte(1'b0, 8'h5A);
        send_byte(1'b0, 8'hC3);
        send_byte(1'b1, {4'b1110, 3'd3, 1'b1});
        send_byte(1'b0, 8'd4);
        wait_credits_back();
        idle(30);
        check_value("bad_code", rx_expected, rx_count);
        check_value("bad_code", bytes_sent - sent0, credit_returned - ret0);
        credit_ahead <= 0;
        set_pointer(3'd3, 8'h40);
        start_read(3'd3, 6);
        finish_read("bad_code");
        end_test("bad_code");

        sent0 = bytes_sent;
        ret0  = credit_returned;
        write_frame(3'd5, 8'h80, 12);
        set_pointer(3'd5, 8'h80);
        grant_on <= 1'b0;
        start_read(3'd5, 12);
        wait_credits_back();
        idle(40);
        check_value("back_pressure", rd_base, rx_count);
        grant_on <= 1'b1;
        finish_read("back_pressure");
        check_value("back_pressure", bytes_sent - sent0, credit_returned - ret0);
        end_test("back_pressure");

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

//--- flist.f
hdl/eeprom_pkg.sv
hdl/eeprom_op_if.sv
hdl/frame_decoder.sv
hdl/array_executor.sv
hdl/read_return_queue.sv
hdl/serial_eeprom.sv
tests/serial_eeprom_props.sv
tests/tb_serial_eeprom.sv

//--- Makefile
TOP = tb_serial_eeprom

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "All tests passed"

clean:
	rm -rf obj_dir
